// File: fpMulPkg.sv
`default_nettype none

package fpMulPkg;

    // binary32 field view
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frc;
    } fp32Fields;

    // one float word, read raw or by fields
    typedef union packed {
        logic [31:0] raw;
        fp32Fields   f;
    } fp32U;

    // codes 5 to 7 fall back to rne
    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } roundModeE;

    typedef enum logic [1:0] {
        spNone = 2'd0,
        spZero = 2'd1,
        spInf  = 2'd2,
        spNan  = 2'd3
    } specialE;

    typedef struct packed {
        logic isZero;
        logic isSub;
        logic isInf;
        logic isNan;
    } opClassT;

    typedef struct packed {
        logic        valid;
        logic        sign;
        logic [7:0]  expX;
        logic [7:0]  expY;
        logic [23:0] sigX;
        logic [23:0] sigY;
        opClassT     clsX;
        opClassT     clsY;
        roundModeE   rMode;
    } decodeT;

    typedef struct packed {
        logic              valid;
        logic              sign;
        logic signed [9:0] expSum;
        logic [47:0]       frcFull;
        specialE           special;
        roundModeE         rMode;
    } productT;

    typedef struct packed {
        logic valid;
        fp32U z;
        logic ovrf;
        logic udrf;
    } resultT;

    localparam logic [31:0] canonNan = 32'h7FC00000;
    localparam int          biasC    = 127;

endpackage

`default_nettype wire

// File: fpMulDecode.sv
`timescale 1ns/100ps
`default_nettype none

module fpMulDecode
    import fpMulPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      inValid,
    input  fp32U      x,
    input  fp32U      y,
    input  roundModeE rMode,
    output decodeT    dec
);

    opClassT clsX;
    opClassT clsY;

    // classify by exponent and fraction fields
    function automatic opClassT classify(fp32U v);
        opClassT c;
        c.isZero = (v.f.exp == 8'h00) && (v.f.frc == '0);
        c.isSub  = (v.f.exp == 8'h00) && (v.f.frc != '0);
        c.isInf  = (v.f.exp == 8'hFF) && (v.f.frc == '0);
        c.isNan  = (v.f.exp == 8'hFF) && (v.f.frc != '0);
        return c;
    endfunction

    // hidden bit; subnormals flush to zero
    function automatic logic [23:0] significand(fp32U v);
        return (v.f.exp == 8'h00) ? 24'd0 : {1'b1, v.f.frc};
    endfunction

    assign clsX = classify(x);
    assign clsY = classify(y);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dec <= '0;
        end else begin
            dec.valid <= inValid;
            dec.sign  <= x.f.sign ^ y.f.sign;
            dec.expX  <= x.f.exp;
            dec.expY  <= y.f.exp;
            dec.sigX  <= significand(x);
            dec.sigY  <= significand(y);
            dec.clsX  <= clsX;
            dec.clsY  <= clsY;
            dec.rMode <= rMode;
        end
    end

    // nan flag only ever comes from an all-ones exponent
    decNanExp: assert property (@(posedge clk) disable iff (!arstN)
        dec.valid && (dec.clsX.isNan || dec.clsY.isNan) |->
            (!dec.clsX.isNan || dec.expX == 8'hFF) &&
            (!dec.clsY.isNan || dec.expY == 8'hFF));

endmodule

`default_nettype wire

// File: fpMulBooth.sv
`timescale 1ns/100ps
`default_nettype none

module fpMulBooth
    import fpMulPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  decodeT  dec,
    output productT prod
);

    // multiplier with an implicit zero below bit 0 and two zeros on top
    logic [26:0]       yExt;
    logic [25:0]       pp;
    logic [47:0]       acc;
    logic signed [9:0] expSum;
    logic              zeroX;
    logic              zeroY;
    specialE           special;

    assign yExt = {2'b00, dec.sigY, 1'b0};

    // 13 radix-4 digits, each selects 0, +-X or +-2X
    always_comb begin
        acc = '0;
        pp  = '0;
        for (int i = 0; i < 13; i++) begin
            case (yExt[2*i+2 -: 3])
                3'b001, 3'b010: pp = {2'b00, dec.sigX};
                3'b011:         pp = {1'b0, dec.sigX, 1'b0};
                3'b100:         pp = -{1'b0, dec.sigX, 1'b0};
                3'b101, 3'b110: pp = -{2'b00, dec.sigX};
                default:        pp = '0;
            endcase
            // sign extend, then weight by 4^i
            acc = acc + ({{22{pp[25]}}, pp} << (2 * i));
        end
    end

    assign expSum = 10'({2'b00, dec.expX}) + 10'({2'b00, dec.expY}) - 10'(biasC);

    // subnormals count as zero
    assign zeroX = dec.clsX.isZero || dec.clsX.isSub;
    assign zeroY = dec.clsY.isZero || dec.clsY.isSub;

    always_comb begin
        if (dec.clsX.isNan || dec.clsY.isNan ||
            (dec.clsX.isInf && zeroY) || (dec.clsY.isInf && zeroX)) begin
            special = spNan;
        end else if (dec.clsX.isInf || dec.clsY.isInf) begin
            special = spInf;
        end else if (zeroX || zeroY) begin
            special = spZero;
        end else begin
            special = spNone;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prod <= '0;
        end else begin
            prod.valid   <= dec.valid;
            prod.sign    <= dec.sign;
            prod.expSum  <= expSum;
            prod.frcFull <= acc;
            prod.special <= special;
            prod.rMode   <= dec.rMode;
        end
    end

    // flushed operand gives an all-zero product next cycle
    boothZeroSig: assert property (@(posedge clk) disable iff (!arstN)
        dec.valid && (dec.sigX == '0 || dec.sigY == '0) |=> prod.frcFull == '0);

endmodule

`default_nettype wire

// File: fpMulNormRound.sv
`timescale 1ns/100ps
`default_nettype none

module fpMulNormRound
    import fpMulPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  productT     prod,
    output resultT      res,
    output logic [25:0] frcNorm,
    output logic        normShift,
    output logic        roundCarry
);

    logic [47:0]       frcShifted;
    logic              lsbBit;
    logic              rndBit;
    logic              stkBit;
    logic              incr;
    logic [22:0]       frcRnd;
    logic signed [9:0] expFinal;
    logic              ovf;
    logic              udf;
    logic              infOnOvf;
    fp32U              zNext;
    logic              ovrfNext;
    logic              udrfNext;

    // one-position normalize; layout is hidden, fraction[23], round, sticky
    assign normShift  = prod.frcFull[47];
    assign frcShifted = normShift ? prod.frcFull : {prod.frcFull[46:0], 1'b0};
    assign frcNorm    = {frcShifted[47:23], |frcShifted[22:0]};

    assign lsbBit = frcNorm[2];
    assign rndBit = frcNorm[1];
    assign stkBit = frcNorm[0];

    always_comb begin
        case (prod.rMode)
            rtz:     incr = 1'b0;
            rdn:     incr = prod.sign && (rndBit || stkBit);
            rup:     incr = !prod.sign && (rndBit || stkBit);
            rmm:     incr = rndBit;
            default: incr = rndBit && (stkBit || lsbBit);
        endcase
    end

    assign {roundCarry, frcRnd} = {1'b0, frcNorm[24:2]} + 24'(incr);

    assign expFinal = prod.expSum + $signed({9'd0, normShift}) + $signed({9'd0, roundCarry});
    assign ovf      = expFinal >= 10'sd255;
    assign udf      = expFinal <= 10'sd0;

    // overflow saturates to max finite unless rounding points outward
    always_comb begin
        case (prod.rMode)
            rtz:     infOnOvf = 1'b0;
            rdn:     infOnOvf = prod.sign;
            rup:     infOnOvf = !prod.sign;
            default: infOnOvf = 1'b1;
        endcase
    end

    always_comb begin
        zNext.f.sign = prod.sign;
        zNext.f.exp  = expFinal[7:0];
        zNext.f.frc  = frcRnd;
        case (prod.special)
            spNan:   zNext.raw = canonNan;
            spInf:   zNext.raw = {prod.sign, 8'hFF, 23'd0};
            spZero:  zNext.raw = {prod.sign, 31'd0};
            default: begin
                if (ovf) begin
                    zNext.raw = infOnOvf ? {prod.sign, 8'hFF, 23'd0}
                                         : {prod.sign, 8'hFE, 23'h7FFFFF};
                end else if (udf) begin
                    zNext.raw = {prod.sign, 31'd0};
                end
            end
        endcase
    end

    assign ovrfNext = prod.valid && (prod.special == spNone) && ovf;
    assign udrfNext = prod.valid && (prod.special == spNone) && udf;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            res <= '0;
        end else begin
            res.valid <= prod.valid;
            res.z     <= zNext;
            res.ovrf  <= ovrfNext;
            res.udrf  <= udrfNext;
        end
    end

    // overflow and underflow are exclusive on every result
    resFlagsExcl: assert property (@(posedge clk) disable iff (!arstN)
        prod.valid |=> res.valid && !(res.ovrf && res.udrf));

endmodule

`default_nettype wire

// File: fpMulChecker.sv
`timescale 1ns/100ps
`default_nettype none

module fpMulChecker
    import fpMulPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  decodeT      dec,
    input  productT     prod,
    input  logic [25:0] frcNorm,
    input  logic        normShift,
    input  logic        roundCarry,
    input  resultT      res
);

    logic        zeroFinite;
    logic        rtzQ;
    logic [22:0] truncQ;
    logic [47:0] sigProd;

    // zero or subnormal against anything finite
    assign zeroFinite =
        ((dec.clsX.isZero || dec.clsX.isSub) && !dec.clsY.isInf && !dec.clsY.isNan) ||
        ((dec.clsY.isZero || dec.clsY.isSub) && !dec.clsX.isInf && !dec.clsX.isNan);

    // plain integer product of the decoded significands
    assign sigProd = 48'(dec.sigX) * 48'(dec.sigY);

    // truncated fraction held one stage for the rtz check
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rtzQ   <= 1'b0;
            truncQ <= '0;
        end else begin
            rtzQ   <= prod.valid && (prod.rMode == rtz) && (prod.special == spNone);
            truncQ <= frcNorm[24:2];
        end
    end

    chkSubIsZero: assert property (@(posedge clk) disable iff (!arstN)
        dec.valid && zeroFinite |-> ##2 res.valid && res.z.raw == {$past(dec.sign, 2), 31'd0});

    chkSign: assert property (@(posedge clk) disable iff (!arstN)
        dec.valid |-> ##2 (res.z.raw == canonNan || res.z.f.sign == $past(dec.sign, 2)));

    chkNormMsb: assert property (@(posedge clk) disable iff (!arstN)
        prod.valid && prod.special == spNone |-> frcNorm[25]);

    // shift decision follows bit 47 of the true significand product
    chkNormShift: assert property (@(posedge clk) disable iff (!arstN)
        dec.valid |=> normShift == $past(sigProd[47]));

    // rtz keeps the truncated fraction unless a flag took over
    chkRtz: assert property (@(posedge clk) disable iff (!arstN)
        rtzQ && !res.ovrf && !res.udrf |-> res.z.f.frc == truncQ);

    chkCarry: assert property (@(posedge clk) disable iff (!arstN)
        prod.valid && roundCarry |-> &frcNorm[24:2]);

endmodule

`default_nettype wire

// File: fpMul.sv
`timescale 1ns/100ps
`default_nettype none

module fpMul
    import fpMulPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      inValid,
    input  fp32U      x,
    input  fp32U      y,
    input  roundModeE rMode,
    output logic      outValid,
    output fp32U      z,
    output logic      ovrf,
    output logic      udrf
);

    decodeT      dec;
    productT     prod;
    resultT      res;
    logic [25:0] frcNorm;
    logic        normShift;
    logic        roundCarry;

    fpMulDecode i_fpMulDecode (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .x       (x),
        .y       (y),
        .rMode   (rMode),
        .dec     (dec)
    );

    fpMulBooth i_fpMulBooth (
        .clk   (clk),
        .arstN (arstN),
        .dec   (dec),
        .prod  (prod)
    );

    fpMulNormRound i_fpMulNormRound (
        .clk        (clk),
        .arstN      (arstN),
        .prod       (prod),
        .res        (res),
        .frcNorm    (frcNorm),
        .normShift  (normShift),
        .roundCarry (roundCarry)
    );

    fpMulChecker i_fpMulChecker (
        .clk        (clk),
        .arstN      (arstN),
        .dec        (dec),
        .prod       (prod),
        .frcNorm    (frcNorm),
        .normShift  (normShift),
        .roundCarry (roundCarry),
        .res        (res)
    );

    assign outValid = res.valid;
    assign z        = res.z;
    assign ovrf     = res.ovrf;
    assign udrf     = res.udrf;

endmodule

`default_nettype wire

// File: fpMulTb.sv
`timescale 1ns/100ps
`default_nettype none

module fpMulTb
    import fpMulPkg::*;
();

    typedef struct packed {
        logic [31:0] z;
        logic        ovrf;
        logic        udrf;
        logic [31:0] cyc;
    } expectT;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int totalOps    = 355;
    localparam int numTests    = 5;
    // every test drains the pipeline and the burst test idles between groups
    localparam int watchdogCycles = resetCycles + totalOps + numTests * 8 + 50;

    logic      clk = 1'b0;
    logic      arstN;
    logic      inValid;
    fp32U      x;
    fp32U      y;
    roundModeE rMode;
    logic      outValid;
    fp32U      z;
    logic      ovrf;
    logic      udrf;

    logic [31:0] cyc;
    int          errors;
    int          checks;
    int          inPulses;
    int          outPulses;
    int          testOps;
    expectT      expQ[$];
    expectT      front;
    expectT      threeSq;
    fp32U        a;
    fp32U        b;

    fpMul i_fpMul (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .x        (x),
        .y        (y),
        .rMode    (rMode),
        .outValid (outValid),
        .z        (z),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // edges since reset release
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // flush to zero, canonical nan, one-step normalize, five rounding modes
    function automatic expectT expectedProduct(input fp32U p, input fp32U q, input roundModeE m);
        expectT      r;
        logic        s;
        logic        nanP;
        logic        nanQ;
        logic        infP;
        logic        infQ;
        logic        zeroP;
        logic        zeroQ;
        logic        rnd;
        logic        stk;
        logic        up;
        logic        carry;
        logic        toInf;
        logic [47:0] prd;
        logic [22:0] frac;
        int          e;
        r     = '0;
        s     = p.f.sign ^ q.f.sign;
        nanP  = (p.f.exp == 8'hFF) && (p.f.frc != 0);
        nanQ  = (q.f.exp == 8'hFF) && (q.f.frc != 0);
        infP  = (p.f.exp == 8'hFF) && (p.f.frc == 0);
        infQ  = (q.f.exp == 8'hFF) && (q.f.frc == 0);
        zeroP = p.f.exp == 8'h00;
        zeroQ = q.f.exp == 8'h00;
        if (nanP || nanQ || (infP && zeroQ) || (infQ && zeroP)) begin
            r.z = 32'h7FC00000;
        end else if (infP || infQ) begin
            r.z = {s, 8'hFF, 23'd0};
        end else if (zeroP || zeroQ) begin
            r.z = {s, 31'd0};
        end else begin
            prd = 48'({1'b1, p.f.frc}) * 48'({1'b1, q.f.frc});
            e   = int'(p.f.exp) + int'(q.f.exp) - 127;
            if (prd[47]) begin
                frac = prd[46:24];
                rnd  = prd[23];
                stk  = |prd[22:0];
                e    = e + 1;
            end else begin
                frac = prd[45:23];
                rnd  = prd[22];
                stk  = |prd[21:0];
            end
            case (m)
                rtz:     up = 1'b0;
                rdn:     up = s && (rnd || stk);
                rup:     up = !s && (rnd || stk);
                rmm:     up = rnd;
                default: up = rnd && (stk || frac[0]);
            endcase
            {carry, frac} = {1'b0, frac} + 24'(up);
            e = e + int'(carry);
            if (e >= 255) begin
                r.ovrf = 1'b1;
                toInf  = (m == rtz) ? 1'b0 : (m == rdn) ? s : (m == rup) ? !s : 1'b1;
                r.z    = toInf ? {s, 8'hFF, 23'd0} : {s, 8'hFE, 23'h7FFFFF};
            end else if (e <= 0) begin
                r.udrf = 1'b1;
                r.z    = {s, 31'd0};
            end else begin
                r.z = {s, 8'(e), frac};
            end
        end
        return r;
    endfunction

    function automatic fp32U randomFloat(input int loExp, input int hiExp);
        fp32U v;
        v.f.sign = 1'($urandom);
        v.f.exp  = 8'($urandom_range(hiExp, loExp));
        v.f.frc  = 23'($urandom);
        return v;
    endfunction

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!arstN || cyc <= 3) begin
            checks++;
            assert (!outValid && !ovrf && !udrf) else begin
                $display("result strobe or flag seen during reset or right after it");
                errors++;
            end
        end else if (outValid) begin
            outPulses++;
            if (expQ.size() == 0) begin
                $display("result appeared with no operation in flight");
                errors++;
            end else begin
                front  = expQ.pop_front();
                checks = checks + 4;
                assert (z.raw == front.z) else begin
                    $display("** Error z: got %h, expected %h", z.raw, front.z);
                    errors++;
                end
                assert (ovrf == front.ovrf) else begin
                    $display("** Error ovrf: got %h, expected %h", ovrf, front.ovrf);
                    errors++;
                end
                assert (udrf == front.udrf) else begin
                    $display("** Error udrf: got %h, expected %h", udrf, front.udrf);
                    errors++;
                end
                assert (cyc - front.cyc == 3) else begin
                    $display("result came %0d cycles after issue instead of 3", cyc - front.cyc);
                    errors++;
                end
            end
        end
    end

    task automatic issue(input fp32U p, input fp32U q, input roundModeE m);
        expectT e;
        e = expectedProduct(p, q, m);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        x       = p;
        y       = q;
        rMode   = m;
        e.cyc   = cyc;
        expQ.push_back(e);
        inPulses++;
        testOps++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    task automatic endTest(input string name);
        int waited;
        waited = 0;
        idle(1);
        while (expQ.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("%0d results never came out of the pipeline", expQ.size());
            errors++;
            expQ.delete();
        end
        $display("%s: %0d operations, %0d errors so far", name, testOps, errors);
        testOps = 0;
    endtask

    initial begin
        void'($urandom(32'h7045bd70));
        arstN     = 1'b0;
        // overflowing pair strobed through reset must never come out
        inValid   = 1'b1;
        x         = 32'h7F000000;
        y         = 32'h7F000000;
        rMode     = rne;
        errors    = 0;
        checks    = 0;
        inPulses  = 0;
        outPulses = 0;
        testOps   = 0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN   = 1'b1;
        inValid = 1'b0;
        repeat (4) @(posedge clk);

        threeSq = expectedProduct(32'h40400000, 32'h40400000, rtz);
        checks++;
        assert (threeSq.z == 32'h41100000) else begin
            $display("** Error model z: got %h, expected %h", threeSq.z, 32'h41100000);
            errors++;
        end
        issue(32'h40400000, 32'h40400000, rtz);
        endTest("3.0 x 3.0 rtz");

        // zero, subnormal, infinity and nan operands
        issue(32'h00000000, 32'hC0200000, rne);
        issue(32'h80000000, 32'h3FC00000, rne);
        issue(32'h00000001, 32'hC0400000, rne);
        issue(32'hC0400000, 32'h807FFFFF, rne);
        issue(32'h7F800000, 32'hC0000000, rne);
        issue(32'hFF800000, 32'hFF800000, rne);
        issue(32'h7F800000, 32'h00000000, rne);
        issue(32'h00000005, 32'hFF800000, rne);
        issue(32'h7FC00000, 32'h3F800000, rne);
        issue(32'h3F800000, 32'hFF800001, rne);
        endTest("special operands");

        for (int i = 0; i < 300; i++) begin
            issue(randomFloat(64, 190), randomFloat(64, 190), roundModeE'(i % 5));
        end
        endTest("random normal pairs");

        // product sign set by a alone so rdn and rup see both directions
        for (int m = 0; m < 5; m++) begin
            for (int sgn = 0; sgn < 2; sgn++) begin
                a        = randomFloat(240, 254);
                b        = randomFloat(240, 254);
                a.f.sign = 1'(sgn);
                b.f.sign = 1'b0;
                issue(a, b, roundModeE'(m));
                a        = randomFloat(1, 40);
                b        = randomFloat(1, 40);
                a.f.sign = 1'(sgn);
                b.f.sign = 1'b0;
                issue(a, b, roundModeE'(m));
            end
        end
        endTest("overflow and underflow");

        for (int g = 0; g < 4; g++) begin
            for (int i = 0; i < 6; i++) begin
                issue(randomFloat(100, 154), randomFloat(100, 154), roundModeE'($urandom % 5));
            end
            idle(g + 1);
        end
        endTest("bursts with gaps");
        checks++;
        assert (inPulses == outPulses) else begin
            $display("%0d operations issued but %0d results seen", inPulses, outPulses);
            errors++;
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired, the run hung before all operations completed");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
fpMulPkg.sv
fpMulDecode.sv
fpMulBooth.sv
fpMulNormRound.sv
fpMulChecker.sv
fpMul.sv
fpMulTb.sv

// File: Bender.yml
package:
  name: fpMul

sources:
  - fpMulPkg.sv
  - fpMulDecode.sv
  - fpMulBooth.sv
  - fpMulNormRound.sv
  - fpMulChecker.sv
  - fpMul.sv
  - target: simulation
    files:
      - fpMulTb.sv
